//--- src.f
+incdir+design
design/mac_io_pkg.sv
design/mac_bus_ctrl.sv
design/via_port_regs.sv
design/via_timers.sv
design/via_shift_kbd.sv
design/via_irq_ctrl.sv
design/mac_io_top.sv
tb/mac_io_properties.sv
tb/tb_mac_io.sv

//--- tb/tb_mac_io.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mac_io;
  import mac_io_pkg::*;

  localparam int RESET_CYCLES    = 16;
  localparam int DECODE_CYCLES   = 400;
  localparam int REGS_CYCLES     = 400;
  localparam int IRQ_CYCLES      = 4000;   // 60 vsync pulses plus register traffic
  localparam int KBD_CYCLES      = 400;
  localparam int TIMER_CYCLES    = 1200;   // Worst case N = 19
  localparam int MARGIN_CYCLES   = 5600;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + DECODE_CYCLES + REGS_CYCLES + IRQ_CYCLES +
                                   KBD_CYCLES + TIMER_CYCLES + MARGIN_CYCLES;

  logic        clk_cpu;
  logic        reset;
  cpu_bus_t    cpu_bus;
  cpu_word_t   rom_rdata;
  cpu_word_t   ram_rdata;
  logic        vsync;
  logic        hsync;
  via_byte_t   kbd_in_data;
  logic        kbd_in_strobe;
  cpu_word_t   cpu_din;
  chip_sel_t   mem_sel;
  cpu_waddr_t  ram_addr;
  ipl_t        ipl_n;
  via_byte_t   kbd_out_data;
  logic        kbd_out_strobe;
  logic        audio;
  logic [31:0] lfsr_state;
  int          value_errors;
  int          other_errors;
  int          strobe_count = 0;   // Keyboard-out pulses seen so far
  via_byte_t   strobe_data;
  cpu_waddr_t  read_ram_addr;      // RAM address seen by the last bus read

  mac_io_top DUT (
    .clk_cpu          (clk_cpu),
    .reset            (reset),
    .cpu_bus_i        (cpu_bus),
    .rom_rdata_i      (rom_rdata),
    .ram_rdata_i      (ram_rdata),
    .vsync_i          (vsync),
    .hsync_i          (hsync),
    .kbd_in_data_i    (kbd_in_data),
    .kbd_in_strobe_i  (kbd_in_strobe),
    .cpu_din_o        (cpu_din),
    .mem_sel_o        (mem_sel),
    .ram_addr_o       (ram_addr),
    .ipl_n_o          (ipl_n),
    .kbd_out_data_o   (kbd_out_data),
    .kbd_out_strobe_o (kbd_out_strobe),
    .audio_o          (audio)
  );

  initial begin
    clk_cpu = 1'b0;
    forever #20 clk_cpu = ~clk_cpu;   // 40 ns period
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_cpu);
    $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // Sampled mid-cycle, away from the launching edge
  always @(negedge clk_cpu) begin
    if (kbd_out_strobe) begin
      strobe_count <= strobe_count + 1;
      strobe_data  <= kbd_out_data;
    end
  end

  // ============================================================
  // Helpers
  // ============================================================
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // Taps 32,22,2,1
  endfunction

  function automatic via_byte_t rand_byte();
    via_byte_t b;
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_next(lfsr_state);   // One step per bit
      b[i] = lfsr_state[0];
    end
    return b;
  endfunction

  function automatic logic [23:0] via_addr(input via_reg_t r);
    return 24'hE80000 | (24'(r) << 9);     // RS3..RS0 on A12:A9
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
    value_errors++;
  endtask

  task automatic report_problem(input string what);
    $display("ERROR %s", what);
    other_errors++;
  endtask

  task automatic drive_bus(input logic [23:0] addr, input logic rw, input logic uds_n,
                           input cpu_word_t wdata);
    cpu_bus <= '{addr: addr[23:1], rw: rw, uds_n: uds_n, lds_n: uds_n, wdata: wdata};
  endtask

  task automatic bus_write(input logic [23:0] addr, input cpu_word_t data);
    @(posedge clk_cpu);
    drive_bus(addr, 1'b0, 1'b0, data);
    @(posedge clk_cpu);                    // Write lands on this edge
    drive_bus(24'h0, 1'b1, 1'b1, 16'h0);
  endtask

  task automatic bus_read(input logic [23:0] addr, output cpu_word_t data,
                          output chip_sel_t sel);
    @(posedge clk_cpu);
    drive_bus(addr, 1'b1, 1'b0, 16'h0);
    @(negedge clk_cpu);
    data          = cpu_din;
    sel           = mem_sel;
    read_ram_addr = ram_addr;
    @(posedge clk_cpu);
    drive_bus(24'h0, 1'b1, 1'b1, 16'h0);
  endtask

  task automatic via_write(input via_reg_t r, input via_byte_t b);
    bus_write(via_addr(r), {b, 8'h00});
  endtask

  task automatic via_read(input via_reg_t r, output cpu_word_t data);
    chip_sel_t s;
    bus_read(via_addr(r), data, s);
  endtask

  task automatic vsync_pulse();
    @(posedge clk_cpu);
    vsync <= 1'b1;
    repeat (2) @(posedge clk_cpu);
    vsync <= 1'b0;                         // Falling edge is the vblank event
    repeat (2) @(posedge clk_cpu);
  endtask

  // ============================================================
  // Tests
  // ============================================================
  task automatic test_decode();
    cpu_word_t   d;
    chip_sel_t   s;
    cpu_word_t   rom_w;
    cpu_word_t   ram_w;
    cpu_word_t   ram_off;
    logic [23:0] addrs [6];
    logic [5:0]  sels [6];
    addrs = '{24'h000000, 24'h600000, 24'h580000, 24'h900000, 24'hD00000, 24'hE80000};
    sels  = '{6'b100000, 6'b010000, 6'b001000, 6'b000100, 6'b000010, 6'b000001};
    via_read(4'hF, d);
    if (d !== 16'h7FEF) report_mismatch("decode porta reset", 16'h7FEF, d);
    via_read(4'hB, d);
    if (d !== 16'h00EF) report_mismatch("decode acr reset", 16'h00EF, d);
    for (int i = 0; i < 6; i++) begin
      bus_read(addrs[i], d, s);
      if (s !== sels[i]) report_mismatch("decode select", 16'(sels[i]), 16'(s));
    end
    rom_w = {rand_byte(), rand_byte()};
    ram_w = {rand_byte(), rand_byte()};
    @(posedge clk_cpu);
    rom_rdata <= rom_w;
    ram_rdata <= ram_w;
    bus_read(24'h000000, d, s);
    if (d !== rom_w) report_mismatch("decode rom data", rom_w, d);
    bus_read(24'h600000, d, s);
    if (d !== ram_w) report_mismatch("decode ram data", ram_w, d);
    ram_off = {rand_byte(), rand_byte()};  // Word offset into RAM
    bus_read(24'h600000 + {ram_off, 1'b0}, d, s);
    if (read_ram_addr !== 23'(ram_off))
      report_mismatch("decode ram address", 32'(ram_off), 32'(read_ram_addr));
    bus_read(24'hDFFDFE, d, s);
    if (d !== 16'h1F1F) report_mismatch("decode iwm constant", 16'h1F1F, d);
    via_write(4'hF, 8'h6F);                // Overlay on
    bus_read(24'h000000, d, s);
    if (s !== 6'b010000) report_mismatch("decode overlay select", 16'h0010, 16'(s));
    if (d !== ram_w) report_mismatch("decode overlay data", ram_w, d);
    bus_read({7'h00, ram_off, 1'b0}, d, s);
    if (read_ram_addr !== 23'(ram_off))
      report_mismatch("decode overlay address", 32'(ram_off), 32'(read_ram_addr));
    via_write(4'hF, 8'h7F);
  endtask

  task automatic test_regs();
    cpu_word_t d;
    via_byte_t r;
    via_byte_t p;
    r = rand_byte();
    via_write(4'hB, r);
    via_read(4'hB, d);
    if (d !== {r, 8'hEF}) report_mismatch("regs acr", {r, 8'hEF}, d);
    via_write(4'hB, 8'h00);
    r = rand_byte();
    via_write(4'hF, r);
    via_read(4'hF, d);
    if (d !== {1'b0, r[6:0], 8'hEF}) report_mismatch("regs porta", {1'b0, r[6:0], 8'hEF}, d);
    via_write(4'hF, 8'h7F);
    r = rand_byte();                       // DDR, only B0 kept
    via_write(4'h2, r);
    via_read(4'h2, d);
    if (d !== {7'b1000011, r[0], 8'hEF}) report_mismatch("regs ddrb", {7'b1000011, r[0], 8'hEF}, d);
    p = rand_byte();
    via_write(4'h0, p);
    for (int h = 0; h < 2; h++) begin      // Both hsync levels
      @(posedge clk_cpu);
      hsync <= h[0];
      via_read(4'h0, d);
      if (d !== {p[7], ~h[0], 3'b000, p[2:1], r[0] & p[0], 8'hEF})
        report_mismatch("regs portb", {p[7], ~h[0], 3'b000, p[2:1], r[0] & p[0], 8'hEF}, d);
    end
    @(posedge clk_cpu);
    hsync <= 1'b0;
    @(negedge clk_cpu);
    if (audio !== p[7]) report_mismatch("regs audio", 16'(p[7]), 16'(audio));
    for (int i = 4; i < 8; i++) begin      // Timer 1 bytes are plain storage
      r = rand_byte();
      via_write(via_reg_t'(i), r);
      via_read(via_reg_t'(i), d);
      if (d !== {r, 8'hEF}) report_mismatch("regs timer1", {r, 8'hEF}, d);
    end
  endtask

  task automatic test_irq();
    cpu_word_t d;
    via_write(4'hD, 8'h7F);                // Clear all flags
    vsync_pulse();                         // Edge 1
    via_read(4'hD, d);
    if (d !== 16'h82EF) report_mismatch("irq vblank set", 16'h82EF, d);
    @(negedge clk_cpu);
    if (ipl_n !== 3'b111) report_mismatch("irq ipl masked", 16'h0007, 16'(ipl_n));
    via_write(4'hE, 8'h82);
    @(negedge clk_cpu);
    if (ipl_n !== 3'b110) report_mismatch("irq ipl enabled", 16'h0006, 16'(ipl_n));
    via_write(4'hD, 8'h02);
    via_read(4'hD, d);
    if (d !== 16'h80EF) report_mismatch("irq vblank clear", 16'h80EF, d);
    repeat (58) vsync_pulse();             // Edges 2 to 59
    via_read(4'hD, d);
    if (d !== 16'h02EF) report_mismatch("irq before onesec", 16'h02EF, d);
    vsync_pulse();                         // Edge 60
    via_read(4'hD, d);
    if (d !== 16'h03EF) report_mismatch("irq onesec set", 16'h03EF, d);
    via_read(4'hF, d);
    via_read(4'hD, d);
    if (d !== 16'h80EF) report_mismatch("irq porta read clear", 16'h80EF, d);
    via_write(4'hE, 8'h02);
    @(negedge clk_cpu);
    if (ipl_n !== 3'b111) report_mismatch("irq ipl disabled", 16'h0007, 16'(ipl_n));
  endtask

  task automatic test_kbd();
    cpu_word_t d;
    via_byte_t k;
    int        n;
    via_write(4'hB, 8'h0C);                // SR mode 011
    via_write(4'hD, 8'h7F);
    k = rand_byte();
    @(posedge clk_cpu);
    kbd_in_data   <= k;
    kbd_in_strobe <= 1'b1;
    @(posedge clk_cpu);
    kbd_in_strobe <= 1'b0;
    via_read(4'hD, d);
    if (d !== 16'h84EF) report_mismatch("kbd keyready set", 16'h84EF, d);
    via_read(4'hA, d);
    if (d !== {k, 8'hEF}) report_mismatch("kbd byte in", {k, 8'hEF}, d);
    via_read(4'hD, d);
    if (d !== 16'h80EF) report_mismatch("kbd keyready clear", 16'h80EF, d);
    via_write(4'hB, 8'h1C);                // SR mode 111
    n = strobe_count;
    k = rand_byte();
    via_write(4'hA, k);
    repeat (4) @(posedge clk_cpu);
    if (strobe_count != n + 1)
      report_problem($sformatf("kbd_out_strobe_o gave %0d pulses for one write",
                               strobe_count - n));
    if (strobe_data !== k) report_mismatch("kbd byte out", 16'(k), 16'(strobe_data));
    via_read(4'hD, d);
    if (d !== 16'h84EF) report_mismatch("kbd send keyready", 16'h84EF, d);
    via_write(4'hD, 8'h7F);
    via_write(4'hB, 8'h00);
  endtask

  task automatic test_timer2();
    cpu_word_t d;
    via_byte_t b;
    int        n;
    int        lo;
    int        hi;
    int        cycles;
    logic      found;
    b  = rand_byte();
    n  = 4 + b[3:0];
    lo = (n - 1) * 32;
    hi = (n + 2) * 32;
    via_write(4'hD, 8'h7F);
    via_write(4'h8, 8'(n));                // Latch low
    via_write(4'h9, 8'h00);                // Load and arm
    @(posedge clk_cpu);
    drive_bus(via_addr(4'hD), 1'b1, 1'b0, 16'h0);   // Hold an IFR read, no side effect
    cycles = 1;
    found  = 1'b0;
    while (!found && cycles <= hi + 32) begin
      @(negedge clk_cpu);
      cycles++;
      if (cpu_din[8 + 5]) found = 1'b1;    // T2 flag in the high byte
    end
    @(posedge clk_cpu);
    drive_bus(24'h0, 1'b1, 1'b1, 16'h0);
    if (!found)
      report_problem($sformatf("Timer 2 flag never set for count %0d", n));
    else if (cycles < lo || cycles > hi)
      report_problem($sformatf("Timer 2 flag set after %0d cycles, window %0d to %0d",
                               cycles, lo, hi));
    via_read(4'h8, d);
    via_read(4'hD, d);
    if (d !== 16'h80EF) report_mismatch("timer2 flag clear", 16'h80EF, d);
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    lfsr_state    = 32'h5330_c210;
    value_errors  = 0;
    other_errors  = 0;
    reset         = 1'b1;
    cpu_bus       = '{addr: '0, rw: 1'b1, uds_n: 1'b1, lds_n: 1'b1, wdata: '0};
    rom_rdata     = '0;
    ram_rdata     = '0;
    vsync         = 1'b0;
    hsync         = 1'b0;
    kbd_in_data   = '0;
    kbd_in_strobe = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_cpu);
    reset <= 1'b0;
    test_decode();
    test_regs();
    test_irq();
    test_kbd();
    test_timer2();
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/mac_io_properties.sv
`timescale 1ns/10ps
`default_nettype none

module mac_io_properties (
  input wire                        clk_cpu,
  input wire                        reset,
  input wire                        kbd_out_strobe_o,
  input wire [2:0]                  ipl_n_o,
  input wire mac_io_pkg::chip_sel_t mem_sel_o
);

  // Keyboard-out strobe is a single-cycle pulse
  strobe_one_cycle: assert property (@(posedge clk_cpu) disable iff (reset)
    kbd_out_strobe_o |=> !kbd_out_strobe_o)
    else $error("kbd_out_strobe_o high for two cycles");

  // Only one autovector level exists
  ipl_legal: assert property (@(posedge clk_cpu) disable iff (reset)
    (ipl_n_o == 3'b110) || (ipl_n_o == 3'b111))
    else $error("ipl_n_o has an illegal level %b", ipl_n_o);

  // Decode regions never overlap
  sel_onehot0: assert property (@(posedge clk_cpu) disable iff (reset)
    $onehot0(mem_sel_o))
    else $error("More than one chip select active: %b", mem_sel_o);

endmodule

bind mac_io_top mac_io_properties u_properties (.*);

`default_nettype wire

//--- design/mac_io_top.sv
`timescale 1ns/10ps
`default_nettype none

module mac_io_top (
  input  wire                     clk_cpu,
  input  wire                     reset,
  input  mac_io_pkg::cpu_bus_t    cpu_bus_i,
  input  mac_io_pkg::cpu_word_t   rom_rdata_i,
  input  mac_io_pkg::cpu_word_t   ram_rdata_i,
  input  wire                     vsync_i,
  input  wire                     hsync_i,
  input  mac_io_pkg::via_byte_t   kbd_in_data_i,
  input  wire                     kbd_in_strobe_i,
  output mac_io_pkg::cpu_word_t   cpu_din_o,
  output mac_io_pkg::chip_sel_t   mem_sel_o,
  output mac_io_pkg::cpu_waddr_t  ram_addr_o,
  output mac_io_pkg::ipl_t        ipl_n_o,
  output mac_io_pkg::via_byte_t   kbd_out_data_o,
  output logic                    kbd_out_strobe_o,
  output logic                    audio_o
);
  import mac_io_pkg::*;

  // ============================================================
  // Interconnect
  // ============================================================
  via_access_t  via_acc;     // Decoded VIA access, to every VIA block
  via_byte_t    via_rdata;
  logic         overlay_n;   // Port A bit 4
  logic [2:0]   acr_sr_mode;
  via_byte_t    timer_rdata;
  via_byte_t    sr;
  via_irq_vec_t ifr;
  via_irq_vec_t ier;
  irq_event_t   t2_evt;      // Only the T2 fields are live
  logic         kbd_set;
  irq_event_t   irq_evt;

  // Merge datapath events for the interrupt block
  assign irq_evt = '{t2_set: t2_evt.t2_set, t2_clr: t2_evt.t2_clr, kbd_set: kbd_set};

  mac_bus_ctrl u_bus_ctrl (
    .cpu_bus_i   (cpu_bus_i),
    .overlay_n_i (overlay_n),
    .via_rdata_i (via_rdata),
    .rom_rdata_i (rom_rdata_i),
    .ram_rdata_i (ram_rdata_i),
    .mem_sel_o   (mem_sel_o),
    .ram_addr_o  (ram_addr_o),
    .via_acc_o   (via_acc),
    .cpu_din_o   (cpu_din_o)
  );

  via_port_regs u_port_regs (
    .clk_cpu       (clk_cpu),
    .reset         (reset),
    .via_acc_i     (via_acc),
    .hsync_i       (hsync_i),
    .timer_rdata_i (timer_rdata),
    .sr_i          (sr),
    .ifr_i         (ifr),
    .ier_i         (ier),
    .via_rdata_o   (via_rdata),
    .overlay_n_o   (overlay_n),
    .acr_sr_mode_o (acr_sr_mode),
    .audio_o       (audio_o)
  );

  via_timers u_timers (
    .clk_cpu       (clk_cpu),
    .reset         (reset),
    .via_acc_i     (via_acc),
    .timer_rdata_o (timer_rdata),
    .t2_evt_o      (t2_evt)
  );

  via_shift_kbd u_shift_kbd (
    .clk_cpu          (clk_cpu),
    .reset            (reset),
    .via_acc_i        (via_acc),
    .acr_sr_mode_i    (acr_sr_mode),
    .kbd_in_data_i    (kbd_in_data_i),
    .kbd_in_strobe_i  (kbd_in_strobe_i),
    .sr_o             (sr),
    .kbd_out_data_o   (kbd_out_data_o),
    .kbd_out_strobe_o (kbd_out_strobe_o),
    .kbd_set_o        (kbd_set)
  );

  via_irq_ctrl u_irq_ctrl (
    .clk_cpu   (clk_cpu),
    .reset     (reset),
    .via_acc_i (via_acc),
    .irq_evt_i (irq_evt),
    .vsync_i   (vsync_i),
    .ifr_o     (ifr),
    .ier_o     (ier),
    .ipl_n_o   (ipl_n_o)
  );

endmodule

`default_nettype wire

//--- design/via_irq_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "mac_io_config.svh"

module via_irq_ctrl (
  input  wire                       clk_cpu,
  input  wire                       reset,
  input  mac_io_pkg::via_access_t   via_acc_i,
  input  mac_io_pkg::irq_event_t    irq_evt_i,
  input  wire                       vsync_i,
  output mac_io_pkg::via_irq_vec_t  ifr_o,
  output mac_io_pkg::via_irq_vec_t  ier_o,
  output mac_io_pkg::ipl_t          ipl_n_o
);
  import mac_io_pkg::*;

  via_irq_vec_t ifr_nxt;
  logic         vsync_q;
  logic [5:0]   vsync_cnt;   // Vblanks in the current second
  logic         vblank;
  logic         onesec;

  assign vblank = vsync_q & ~vsync_i;   // Falling edge
  assign onesec = vblank & (vsync_cnt == 6'(`VBLANKS_PER_SEC - 1));

  // ============================================================
  // Next flag value, set events last
  // ============================================================
  always_comb begin
    ifr_nxt = ifr_o;
    if (via_acc_i.wr && via_acc_i.reg_sel == `VIA_REG_IFR)
      ifr_nxt = ifr_nxt & ~via_acc_i.wdata[6:0];    // Write 1 to clear
    if (via_acc_i.rd) begin
      case (via_acc_i.reg_sel)
        `VIA_REG_PORTB: begin
          ifr_nxt[`INT_KEYCLK] = 1'b0;
          ifr_nxt[`INT_KEYBIT] = 1'b0;
        end
        `VIA_REG_SR:    ifr_nxt[`INT_KEYREADY] = 1'b0;
        `VIA_REG_PORTA: begin
          ifr_nxt[`INT_ONESEC] = 1'b0;
          ifr_nxt[`INT_VBLANK] = 1'b0;
        end
        default: ;
      endcase
    end
    if (irq_evt_i.t2_clr)  ifr_nxt[`INT_T2]       = 1'b0;
    if (irq_evt_i.t2_set)  ifr_nxt[`INT_T2]       = 1'b1;
    if (irq_evt_i.kbd_set) ifr_nxt[`INT_KEYREADY] = 1'b1;
    if (vblank)            ifr_nxt[`INT_VBLANK]   = 1'b1;
    if (onesec)            ifr_nxt[`INT_ONESEC]   = 1'b1;
  end

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      ifr_o     <= '0;
      ier_o     <= '0;
      vsync_q   <= 1'b0;
      vsync_cnt <= '0;
    end else begin
      ifr_o   <= ifr_nxt;
      vsync_q <= vsync_i;
      if (vblank) vsync_cnt <= onesec ? 6'd0 : vsync_cnt + 1'b1;
      // Bit 7 picks set or clear
      if (via_acc_i.wr && via_acc_i.reg_sel == `VIA_REG_IER) begin
        if (via_acc_i.wdata[7]) ier_o <= ier_o | via_acc_i.wdata[6:0];
        else                    ier_o <= ier_o & ~via_acc_i.wdata[6:0];
      end
    end
  end

  // Single autovector level
  assign ipl_n_o = |(ifr_o & ier_o) ? 3'b110 : 3'b111;

endmodule

`default_nettype wire

//--- design/via_shift_kbd.sv
`timescale 1ns/10ps
`default_nettype none

`include "mac_io_config.svh"

module via_shift_kbd (
  input  wire                      clk_cpu,
  input  wire                      reset,
  input  mac_io_pkg::via_access_t  via_acc_i,
  input  wire [2:0]                acr_sr_mode_i,
  input  mac_io_pkg::via_byte_t    kbd_in_data_i,
  input  wire                      kbd_in_strobe_i,
  output mac_io_pkg::via_byte_t    sr_o,
  output mac_io_pkg::via_byte_t    kbd_out_data_o,
  output logic                     kbd_out_strobe_o,
  output logic                     kbd_set_o
);
  import mac_io_pkg::*;

  logic sr_wr;     // CPU write to SR
  logic kbd_load;  // Byte from keyboard
  logic kbd_send;  // Byte to keyboard

  assign sr_wr    = via_acc_i.wr & (via_acc_i.reg_sel == `VIA_REG_SR);
  assign kbd_load = kbd_in_strobe_i & (acr_sr_mode_i == `ACR_SR_EXT_IN);
  assign kbd_send = sr_wr & (acr_sr_mode_i == `ACR_SR_OUT);

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      sr_o             <= '0;
      kbd_out_strobe_o <= 1'b0;
    end else begin
      kbd_out_strobe_o <= kbd_send;                  // High one clock after the write
      if (sr_wr)    sr_o <= via_acc_i.wdata;
      if (kbd_load) sr_o <= kbd_in_data_i;           // Keyboard wins a collision
    end
  end

  assign kbd_out_data_o = sr_o;
  assign kbd_set_o      = kbd_load | kbd_send;       // Byte in or byte gone, both KEYREADY

endmodule

`default_nettype wire

//--- design/via_timers.sv
`timescale 1ns/10ps
`default_nettype none

`include "mac_io_config.svh"

module via_timers (
  input  wire                      clk_cpu,
  input  wire                      reset,
  input  mac_io_pkg::via_access_t  via_acc_i,
  output mac_io_pkg::via_byte_t    timer_rdata_o,
  output mac_io_pkg::irq_event_t   t2_evt_o
);
  import mac_io_pkg::*;

  timer_count_t               t1_count;    // Plain storage, not counted
  timer_count_t               t1_latch;
  via_byte_t                  t2_latch_lo;
  timer_count_t               t2_count;
  logic                       t2_armed;
  logic [`TIMER_DIV_BITS-1:0] clk_div;
  logic                       tick;        // Divided timer strobe
  logic                       t2_load;
  logic                       t2_fire;

  assign tick    = (clk_div == '0);
  assign t2_load = via_acc_i.wr & (via_acc_i.reg_sel == `VIA_REG_T2CH);
  assign t2_fire = tick & t2_armed & (t2_count == '0);

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      t1_count    <= '0;
      t1_latch    <= '0;
      t2_latch_lo <= '0;
      t2_count    <= '0;
      t2_armed    <= 1'b0;
      clk_div     <= '0;
      t2_evt_o.t2_set <= 1'b0;
    end else begin
      clk_div         <= clk_div + 1'b1;   // Free running
      t2_evt_o.t2_set <= t2_fire;          // One clock pulse
      if (tick) t2_count <= t2_count - 1'b1;
      if (t2_fire) t2_armed <= 1'b0;       // One-shot
      if (via_acc_i.wr) begin
        case (via_acc_i.reg_sel)
          `VIA_REG_T1CL: t1_count[7:0]  <= via_acc_i.wdata;
          `VIA_REG_T1CH: t1_count[15:8] <= via_acc_i.wdata;
          `VIA_REG_T1LL: t1_latch[7:0]  <= via_acc_i.wdata;
          `VIA_REG_T1LH: t1_latch[15:8] <= via_acc_i.wdata;
          `VIA_REG_T2CL: t2_latch_lo    <= via_acc_i.wdata;
          default: ;
        endcase
      end
      if (t2_load) begin                   // High byte write starts T2
        t2_count <= {via_acc_i.wdata, t2_latch_lo};
        t2_armed <= 1'b1;
      end
    end
  end

  // Flag clears on T2 start or low-byte read
  assign t2_evt_o.t2_clr  = t2_load |
                            (via_acc_i.rd & (via_acc_i.reg_sel == `VIA_REG_T2CL));
  assign t2_evt_o.kbd_set = 1'b0;

  always_comb begin
    case (via_acc_i.reg_sel)
      `VIA_REG_T1CL: timer_rdata_o = t1_count[7:0];
      `VIA_REG_T1CH: timer_rdata_o = t1_count[15:8];
      `VIA_REG_T1LL: timer_rdata_o = t1_latch[7:0];
      `VIA_REG_T1LH: timer_rdata_o = t1_latch[15:8];
      `VIA_REG_T2CL: timer_rdata_o = t2_count[7:0];
      `VIA_REG_T2CH: timer_rdata_o = t2_count[15:8];
      default:       timer_rdata_o = 8'h00;
    endcase
  end

endmodule

`default_nettype wire

//--- design/via_port_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "mac_io_config.svh"

module via_port_regs (
  input  wire                        clk_cpu,
  input  wire                        reset,
  input  mac_io_pkg::via_access_t    via_acc_i,
  input  wire                        hsync_i,
  input  mac_io_pkg::via_byte_t      timer_rdata_i,
  input  mac_io_pkg::via_byte_t      sr_i,
  input  mac_io_pkg::via_irq_vec_t   ifr_i,
  input  mac_io_pkg::via_irq_vec_t   ier_i,
  output mac_io_pkg::via_byte_t      via_rdata_o,
  output logic                       overlay_n_o,
  output logic [2:0]                 acr_sr_mode_o,
  output logic                       audio_o
);
  import mac_io_pkg::*;

  via_byte_t port_a;
  via_byte_t port_b;
  logic      ddr_b0;   // Only B0 direction is kept
  via_byte_t acr;
  logic      irq_none;

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      port_a <= `PORTA_RESET;
      port_b <= `PORTB_RESET;
      ddr_b0 <= 1'b1;
      acr    <= '0;
    end else if (via_acc_i.wr) begin
      case (via_acc_i.reg_sel)
        `VIA_REG_PORTB: port_b <= via_acc_i.wdata;
        `VIA_REG_DDRB:  ddr_b0 <= via_acc_i.wdata[0];
        `VIA_REG_ACR:   acr    <= via_acc_i.wdata;
        `VIA_REG_PORTA: port_a <= via_acc_i.wdata;
        default: ;                                   // Owned by other blocks
      endcase
    end
  end

  assign overlay_n_o   = port_a[4];
  assign acr_sr_mode_o = acr[4:2];   // SR mode field
  assign audio_o       = port_b[7];  // Crude sound bit
  assign irq_none      = ~|(ifr_i & ier_i);

  // ============================================================
  // Read mux
  // ============================================================
  always_comb begin
    case (via_acc_i.reg_sel)
      `VIA_REG_PORTB: via_rdata_o = {port_b[7], ~hsync_i, 3'b000, port_b[2:1],
                                     ddr_b0 & port_b[0]};   // Mouse and RTC read 0
      `VIA_REG_DDRB:  via_rdata_o = {7'b1000011, ddr_b0};
      `VIA_REG_DDRA:  via_rdata_o = 8'h7F;
      `VIA_REG_T1CL, `VIA_REG_T1CH, `VIA_REG_T1LL, `VIA_REG_T1LH,
      `VIA_REG_T2CL, `VIA_REG_T2CH:
                      via_rdata_o = timer_rdata_i;
      `VIA_REG_SR:    via_rdata_o = sr_i;
      `VIA_REG_ACR:   via_rdata_o = acr;
      `VIA_REG_PCR:   via_rdata_o = 8'h00;
      `VIA_REG_IFR:   via_rdata_o = {irq_none, ifr_i};
      `VIA_REG_IER:   via_rdata_o = {1'b0, ier_i};
      `VIA_REG_PORTA: via_rdata_o = {1'b0, port_a[6:0]};    // SCC wreq reads 0
      default:        via_rdata_o = `VIA_IDLE_BYTE;
    endcase
  end

endmodule

`default_nettype wire

//--- design/mac_bus_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "mac_io_config.svh"

module mac_bus_ctrl (
  input  mac_io_pkg::cpu_bus_t     cpu_bus_i,
  input  wire                      overlay_n_i,
  input  mac_io_pkg::via_byte_t    via_rdata_i,
  input  mac_io_pkg::cpu_word_t    rom_rdata_i,
  input  mac_io_pkg::cpu_word_t    ram_rdata_i,
  output mac_io_pkg::chip_sel_t    mem_sel_o,
  output mac_io_pkg::cpu_waddr_t   ram_addr_o,
  output mac_io_pkg::via_access_t  via_acc_o,
  output mac_io_pkg::cpu_word_t    cpu_din_o
);
  import mac_io_pkg::*;

  logic        overlaid;    // ROM mirrored at 0 until port A bit 4 drops
  logic [23:0] byte_addr;
  logic [23:0] ram_byte;
  logic        via_access;

  assign overlaid  = ~overlay_n_i;
  assign byte_addr = {cpu_bus_i.addr, 1'b0};

  // ============================================================
  // Address decode on A23:A20
  // ============================================================
  always_comb begin
    mem_sel_o = '0;
    casez (cpu_bus_i.addr[23:20])
      4'b00??: begin
        if (overlaid) mem_sel_o.ram = 1'b1;
        else          mem_sel_o.rom = 1'b1;
      end
      4'b0100: mem_sel_o.rom  = ~cpu_bus_i.addr[17];              // 128k ROM window
      4'b0101: mem_sel_o.scsi = (cpu_bus_i.addr[19:12] == 8'h80);
      4'b0110: mem_sel_o.ram  = ~overlaid;
      4'b10?1: mem_sel_o.scc  = 1'b1;
      4'b1101: mem_sel_o.iwm  = 1'b1;
      4'b1110: mem_sel_o.via  = 1'b1;
      default: mem_sel_o = '0;                                    // Unmapped
    endcase
  end

  // RAM offset depends on overlay
  assign ram_byte   = byte_addr - (overlaid ? 24'h000000 : `RAM_BASE_NORMAL);
  assign ram_addr_o = ram_byte[23:1];

  // VIA on the upper byte lane only
  assign via_access        = mem_sel_o.via & ~cpu_bus_i.uds_n;
  assign via_acc_o.reg_sel = cpu_bus_i.addr[12:9];
  assign via_acc_o.wr      = via_access & ~cpu_bus_i.rw;
  assign via_acc_o.rd      = via_access & cpu_bus_i.rw;
  assign via_acc_o.wdata   = cpu_bus_i.wdata[15:8];

  // ============================================================
  // CPU data-in mux, highest priority first
  // ============================================================
  always_comb begin
    if (mem_sel_o.via)
      cpu_din_o = {via_rdata_i, `VIA_PAD_BYTE};
    else if (byte_addr == `IWM_HACK_ADDR)
      cpu_din_o = `IWM_HACK_DATA;             // Fake IWM status
    else if (cpu_bus_i.addr[23])
      cpu_din_o = '0;                         // Other peripherals read 0
    else if (mem_sel_o.ram)
      cpu_din_o = ram_rdata_i;
    else if (mem_sel_o.rom)
      cpu_din_o = rom_rdata_i;
    else
      cpu_din_o = '0;
  end

endmodule

`default_nettype wire

//--- design/mac_io_pkg.sv
`default_nettype none

package mac_io_pkg;

  typedef logic [23:1] cpu_waddr_t;   // 68000 word address
  typedef logic [15:0] cpu_word_t;    // Bus data word
  typedef logic [7:0]  via_byte_t;    // VIA sits on the high byte lane
  typedef logic [3:0]  via_reg_t;     // RS3..RS0 from A12:A9
  typedef logic [6:0]  via_irq_vec_t; // IFR / IER without bit 7
  typedef logic [15:0] timer_count_t;
  typedef logic [2:0]  ipl_t;         // Active low

  typedef struct packed {
    cpu_waddr_t addr;
    logic       rw;      // 1 = read
    logic       uds_n;
    logic       lds_n;
    cpu_word_t  wdata;
  } cpu_bus_t;

  typedef struct packed {
    logic rom;
    logic ram;
    logic scsi;
    logic scc;
    logic iwm;
    logic via;
  } chip_sel_t;

  typedef struct packed {
    via_reg_t  reg_sel;
    logic      wr;       // One clock per write cycle
    logic      rd;       // Level for the whole read
    via_byte_t wdata;
  } via_access_t;

  typedef struct packed {
    logic t2_set;
    logic t2_clr;
    logic kbd_set;
  } irq_event_t;

endpackage

`default_nettype wire

//--- design/mac_io_config.svh
`ifndef MAC_IO_CONFIG_SVH
`define MAC_IO_CONFIG_SVH

// ============================================================
// VIA register numbers
// ============================================================
`define VIA_REG_PORTB     4'h0
`define VIA_REG_PORTA_HS  4'h1
`define VIA_REG_DDRB      4'h2
`define VIA_REG_DDRA      4'h3
`define VIA_REG_T1CL      4'h4
`define VIA_REG_T1CH      4'h5
`define VIA_REG_T1LL      4'h6
`define VIA_REG_T1LH      4'h7
`define VIA_REG_T2CL      4'h8
`define VIA_REG_T2CH      4'h9
`define VIA_REG_SR        4'hA
`define VIA_REG_ACR       4'hB
`define VIA_REG_PCR       4'hC
`define VIA_REG_IFR       4'hD
`define VIA_REG_IER       4'hE
`define VIA_REG_PORTA     4'hF

// IFR bit positions
`define INT_ONESEC        0
`define INT_VBLANK        1
`define INT_KEYREADY      2
`define INT_KEYBIT        3
`define INT_KEYCLK        4
`define INT_T2            5
`define INT_T1            6

`define VBLANKS_PER_SEC   60
`define TIMER_DIV_BITS    5       // Timer strobe every 32 clocks
`define PORTA_RESET       8'h7F
`define PORTB_RESET       8'hFF
`define ACR_SR_EXT_IN     3'b011  // Shift in under external clock
`define ACR_SR_OUT        3'b111  // Shift out under external clock

// Address map, byte addresses
`define IWM_HACK_ADDR     24'hDFFDFE
`define IWM_HACK_DATA     16'h1F1F
`define RAM_BASE_NORMAL   24'h600000
`define VIA_PAD_BYTE      8'hEF
`define VIA_IDLE_BYTE     8'hBE

`endif
